// ==== hdl/sram_geom_pkg.sv ====
/*
 * SRAM geometry for the test chip: shared port widths and the
 * depth and word width of each of the four dual-port macros
 */
package sram_geom_pkg;

   // Shared port widths
   localparam int ADDR_SIZE  = 10;
   localparam int DATA_SIZE  = 32;
   localparam int WMASK_SIZE = 4;
   localparam int NUM_SRAMS  = 4;

   // Per-macro word counts
   localparam int SRAM_DEPTH0 = 256;
   localparam int SRAM_DEPTH1 = 256;
   localparam int SRAM_DEPTH2 = 512;
   localparam int SRAM_DEPTH3 = 1024;

   // Per-macro word widths, macro 0 is byte wide
   localparam int SRAM_WIDTH0 = 8;
   localparam int SRAM_WIDTH1 = 32;
   localparam int SRAM_WIDTH2 = 32;
   localparam int SRAM_WIDTH3 = 32;

   // Index lookups for generate loops
   function automatic int sram_depth(input int idx);
      case (idx)
         0:       return SRAM_DEPTH0;
         1:       return SRAM_DEPTH1;
         2:       return SRAM_DEPTH2;
         default: return SRAM_DEPTH3;
      endcase
   endfunction

   function automatic int sram_width(input int idx);
      case (idx)
         0:       return SRAM_WIDTH0;
         1:       return SRAM_WIDTH1;
         2:       return SRAM_WIDTH2;
         default: return SRAM_WIDTH3;
      endcase
   endfunction

endpackage

// ==== hdl/sram_cmd_pkg.sv ====
/*
 * Command packet format: opcodes, field offsets of the serial
 * command word and the width of the captured result
 */
package sram_cmd_pkg;

   import sram_geom_pkg::*;

   typedef enum logic [1:0] {
      OP_NOP   = 2'b00,
      OP_WRITE = 2'b01,
      OP_READ  = 2'b10
   } sram_op_e;

   localparam int OP_BITS  = 2;
   localparam int SEL_BITS = $clog2(NUM_SRAMS);

   // Field offsets, built up from the LSB
   // MSB first: opcode, select, addr0, din0, wmask0, addr1
   localparam int ADDR1_LSB  = 0;
   localparam int WMASK0_LSB = ADDR1_LSB + ADDR_SIZE;
   localparam int DIN0_LSB   = WMASK0_LSB + WMASK_SIZE;
   localparam int ADDR0_LSB  = DIN0_LSB + DATA_SIZE;
   localparam int SEL_LSB    = ADDR0_LSB + ADDR_SIZE;
   localparam int OP_LSB     = SEL_LSB + SEL_BITS;

   // 60 bits with the geometry above
   localparam int CMD_WIDTH = OP_LSB + OP_BITS;

   // Port-0 word sits above the port-1 word
   localparam int RESULT_WIDTH = 2 * DATA_SIZE;

   // Shift counter must hold RESULT_WIDTH itself
   localparam int RESULT_CNT_W = $clog2(RESULT_WIDTH + 1);

endpackage

// ==== hdl/scan_loader.sv ====
/*
 * Scan loader: shifts command packets in serially and hands each
 * one to the sequencer over a four-phase req/ack handshake
 */
`timescale 1ns/1ps

module scan_loader (
   input  logic                               clk,
   input  logic                               resetn,
   input  logic                               scan_in_i,
   input  logic                               scan_en_i,
   input  logic                               load_i,
   input  logic                               cmd_ack_i,
   output logic                               cmd_req_o,
   output logic [sram_cmd_pkg::CMD_WIDTH-1:0] cmd_o,
   output logic                               busy_o
);

   import sram_cmd_pkg::*;

   typedef enum logic [1:0] {
      LD_IDLE,
      LD_REQ,
      LD_DROP
   } ld_state_e;

   ld_state_e            state_q;
   logic [CMD_WIDTH-1:0] shift_q;
   logic                 accept;

   // New packets only taken between handshakes
   assign accept = (state_q == LD_IDLE) && load_i;

   // Serial capture, MSB first
   always_ff @(posedge clk) begin
      if (scan_en_i) begin
         shift_q <= {shift_q[CMD_WIDTH-2:0], scan_in_i};
      end
   end

   // Hold copy lets the next packet be scanned during a handshake
   always_ff @(posedge clk) begin
      if (accept) begin
         cmd_o <= shift_q;
      end
   end

   always_ff @(posedge clk) begin
      if (!resetn) begin
         state_q <= LD_IDLE;
      end else begin
         case (state_q)
            LD_IDLE: begin
               if (accept) begin
                  state_q <= LD_REQ;
               end
            end
            LD_REQ: begin
               if (cmd_ack_i) begin
                  state_q <= LD_DROP;
               end
            end
            LD_DROP: begin
               // Wait for the sequencer to release ack
               if (!cmd_ack_i) begin
                  state_q <= LD_IDLE;
               end
            end
            default: state_q <= LD_IDLE;
         endcase
      end
   end

   assign cmd_req_o = (state_q == LD_REQ);
   assign busy_o    = (state_q != LD_IDLE);

   a_cmd_stable: assert property (@(posedge clk) disable iff (!resetn)
      cmd_req_o |=> !cmd_req_o || $stable(cmd_o));

   // Sequencer may only answer an open request
   a_ack_needs_req: assert property (@(posedge clk) disable iff (!resetn)
      $rose(cmd_ack_i) |-> $past(cmd_req_o));

endmodule

// ==== hdl/sram_sequencer.sv ====
/*
 * SRAM sequencer: decodes a command, runs one access on the selected
 * macro and forwards both read words to the result unloader
 */
`timescale 1ns/1ps

module sram_sequencer (
   input  logic                                  clk,
   input  logic                                  resetn,
   input  logic                                  cmd_req_i,
   input  logic [sram_cmd_pkg::CMD_WIDTH-1:0]    cmd_i,
   input  logic                                  cap_ack_i,
   input  logic [sram_geom_pkg::NUM_SRAMS-1:0][sram_geom_pkg::DATA_SIZE-1:0] sram_dout0_i,
   input  logic [sram_geom_pkg::NUM_SRAMS-1:0][sram_geom_pkg::DATA_SIZE-1:0] sram_dout1_i,
   output logic                                  cmd_ack_o,
   output logic [sram_geom_pkg::ADDR_SIZE-1:0]   addr0_o,
   output logic [sram_geom_pkg::DATA_SIZE-1:0]   din0_o,
   output logic                                  web0_o,
   output logic [sram_geom_pkg::WMASK_SIZE-1:0]  wmask0_o,
   output logic [sram_geom_pkg::ADDR_SIZE-1:0]   addr1_o,
   output logic [sram_geom_pkg::NUM_SRAMS-1:0]   csb0_o,
   output logic [sram_geom_pkg::NUM_SRAMS-1:0]   csb1_o,
   output logic                                  cap_req_o,
   output logic [sram_cmd_pkg::RESULT_WIDTH-1:0] cap_data_o
);

   import sram_geom_pkg::*;
   import sram_cmd_pkg::*;

   typedef enum logic [2:0] {
      IDLE,
      ACCESS,
      WAIT_DATA,
      SEND,
      RELEASE
   } seq_state_e;

   seq_state_e           state_q;
   logic [CMD_WIDTH-1:0] cmd_q;
   sram_op_e             req_op;
   sram_op_e             op;
   logic [SEL_BITS-1:0]  sel;
   logic [NUM_SRAMS-1:0] sel_dec;
   logic                 access;

   assign req_op  = sram_op_e'(cmd_i[OP_LSB +: OP_BITS]);
   assign op      = sram_op_e'(cmd_q[OP_LSB +: OP_BITS]);
   assign sel     = cmd_q[SEL_LSB +: SEL_BITS];
   assign sel_dec = NUM_SRAMS'(1) << sel;
   assign access  = (state_q == ACCESS);

   always_ff @(posedge clk) begin
      if (!resetn) begin
         state_q <= IDLE;
      end else begin
         case (state_q)
            IDLE: begin
               if (cmd_req_i) begin
                  // NOP and unused codes skip the macros
                  if (req_op inside {OP_WRITE, OP_READ}) begin
                     state_q <= ACCESS;
                  end else begin
                     state_q <= RELEASE;
                  end
               end
            end
            ACCESS:    state_q <= WAIT_DATA;
            WAIT_DATA: state_q <= SEND;
            SEND: begin
               if (cap_ack_i) begin
                  state_q <= RELEASE;
               end
            end
            RELEASE: begin
               if (!cap_ack_i && !cmd_req_i) begin
                  state_q <= IDLE;
               end
            end
            default: state_q <= IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state_q == IDLE && cmd_req_i) begin
         cmd_q <= cmd_i;
      end
      // Macro outputs are valid one cycle after the chip select
      if (state_q == WAIT_DATA) begin
         cap_data_o <= {sram_dout0_i[sel], sram_dout1_i[sel]};
      end
   end

   // Ack held until the result is handed on, so a full unloader stalls the loader
   assign cmd_ack_o = (state_q != IDLE);
   assign cap_req_o = (state_q == SEND);

   // Shared buses come straight from the held command
   assign addr0_o  = cmd_q[ADDR0_LSB +: ADDR_SIZE];
   assign din0_o   = cmd_q[DIN0_LSB +: DATA_SIZE];
   assign wmask0_o = cmd_q[WMASK0_LSB +: WMASK_SIZE];
   assign addr1_o  = cmd_q[ADDR1_LSB +: ADDR_SIZE];

   assign csb0_o = access ? ~sel_dec : '1;
   assign csb1_o = access ? ~sel_dec : '1;
   assign web0_o = !(access && op == OP_WRITE);

   a_one_csb0: assert property (@(posedge clk) disable iff (!resetn)
      $onehot0(~csb0_o));

   a_web_with_cs: assert property (@(posedge clk) disable iff (!resetn)
      !web0_o |-> !(&csb0_o));

endmodule

// ==== hdl/sram_1rw1r.sv ====
/*
 * Behavioral dual-port SRAM: port 0 reads or writes with a byte
 * mask, port 1 only reads; both outputs registered
 */
`timescale 1ns/1ps

module sram_1rw1r #(
   parameter int DEPTH = 256,
   parameter int WIDTH = 32
) (
   input  logic                                clk,
   input  logic                                csb0_i,
   input  logic                                web0_i,
   input  logic [WIDTH/8-1:0]                  wmask0_i,
   input  logic [sram_geom_pkg::ADDR_SIZE-1:0] addr0_i,
   input  logic [WIDTH-1:0]                    din0_i,
   input  logic                                csb1_i,
   input  logic [sram_geom_pkg::ADDR_SIZE-1:0] addr1_i,
   output logic [WIDTH-1:0]                    dout0_o,
   output logic [WIDTH-1:0]                    dout1_o
);

   logic [WIDTH-1:0] mem [DEPTH];

   // Port 0, upper address bits beyond the depth are ignored
   always_ff @(posedge clk) begin
      if (!csb0_i) begin
         if (!web0_i) begin
            for (int b = 0; b < WIDTH / 8; b++) begin
               if (wmask0_i[b]) begin
                  mem[addr0_i % DEPTH][b*8 +: 8] <= din0_i[b*8 +: 8];
               end
            end
            // Write cycles return zero
            dout0_o <= '0;
         end else begin
            dout0_o <= mem[addr0_i % DEPTH];
         end
      end
   end

   // Port 1 sees the old word on a same-cycle write
   always_ff @(posedge clk) begin
      if (!csb1_i) begin
         dout1_o <= mem[addr1_i % DEPTH];
      end
   end

endmodule

// ==== hdl/result_unloader.sv ====
/*
 * Result unloader: takes one 64-bit result from the sequencer and
 * shifts it out serially, MSB first
 */
`timescale 1ns/1ps

module result_unloader (
   input  logic                                  clk,
   input  logic                                  resetn,
   input  logic                                  cap_req_i,
   input  logic [sram_cmd_pkg::RESULT_WIDTH-1:0] cap_data_i,
   input  logic                                  unload_en_i,
   output logic                                  cap_ack_o,
   output logic                                  scan_out_o,
   output logic                                  done_o
);

   import sram_cmd_pkg::*;

   logic [RESULT_WIDTH-1:0] shift_q;
   logic [RESULT_CNT_W-1:0] count_q;
   logic                    capture;

   // Only an empty unloader answers a new request
   assign capture = cap_req_i && !cap_ack_o && !done_o;

   always_ff @(posedge clk) begin
      if (!resetn) begin
         cap_ack_o <= 1'b0;
         done_o    <= 1'b0;
         count_q   <= '0;
         shift_q   <= '0;
      end else if (capture) begin
         cap_ack_o <= 1'b1;
         done_o    <= 1'b1;
         count_q   <= RESULT_CNT_W'(RESULT_WIDTH);
         shift_q   <= cap_data_i;
      end else begin
         if (!cap_req_i) begin
            cap_ack_o <= 1'b0;
         end
         if (done_o && unload_en_i) begin
            shift_q <= shift_q << 1;
            count_q <= count_q - 1'b1;
            // Last bit gone, ready for the next result
            if (count_q == RESULT_CNT_W'(1)) begin
               done_o <= 1'b0;
            end
         end
      end
   end

   assign scan_out_o = shift_q[RESULT_WIDTH-1];

   // Sequencer holds its result while the request is open
   a_cap_stable: assert property (@(posedge clk) disable iff (!resetn)
      cap_req_i |=> !cap_req_i || $stable(cap_data_i));

endmodule

// ==== hdl/sram_testchip_top.sv ====
/*
 * SRAM test chip top: scan loader, sequencer, four dual-port
 * macros and the serial result unloader
 */
`timescale 1ns/1ps

module sram_testchip_top (
   input  logic clk,
   input  logic resetn,
   input  logic scan_in_i,
   input  logic scan_en_i,
   input  logic load_i,
   input  logic unload_en_i,
   output logic scan_out_o,
   output logic busy_o,
   output logic done_o
);

   import sram_geom_pkg::*;
   import sram_cmd_pkg::*;

   logic                                 cmd_req;
   logic                                 cmd_ack;
   logic [CMD_WIDTH-1:0]                 cmd;
   logic                                 cap_req;
   logic                                 cap_ack;
   logic [RESULT_WIDTH-1:0]              cap_data;

   // Buses shared by all macros
   logic [ADDR_SIZE-1:0]                 addr0;
   logic [ADDR_SIZE-1:0]                 addr1;
   logic [DATA_SIZE-1:0]                 din0;
   logic                                 web0;
   logic [WMASK_SIZE-1:0]                wmask0;
   // One chip select pair per macro
   logic [NUM_SRAMS-1:0]                 csb0;
   logic [NUM_SRAMS-1:0]                 csb1;
   logic [NUM_SRAMS-1:0][DATA_SIZE-1:0]  dout0_all;
   logic [NUM_SRAMS-1:0][DATA_SIZE-1:0]  dout1_all;

   scan_loader u_loader (
      .clk       (clk),
      .resetn    (resetn),
      .scan_in_i (scan_in_i),
      .scan_en_i (scan_en_i),
      .load_i    (load_i),
      .cmd_ack_i (cmd_ack),
      .cmd_req_o (cmd_req),
      .cmd_o     (cmd),
      .busy_o    (busy_o)
   );

   sram_sequencer u_seq (
      .clk          (clk),
      .resetn       (resetn),
      .cmd_req_i    (cmd_req),
      .cmd_i        (cmd),
      .cap_ack_i    (cap_ack),
      .sram_dout0_i (dout0_all),
      .sram_dout1_i (dout1_all),
      .cmd_ack_o    (cmd_ack),
      .addr0_o      (addr0),
      .din0_o       (din0),
      .web0_o       (web0),
      .wmask0_o     (wmask0),
      .addr1_o      (addr1),
      .csb0_o       (csb0),
      .csb1_o       (csb1),
      .cap_req_o    (cap_req),
      .cap_data_o   (cap_data)
   );

   for (genvar g = 0; g < NUM_SRAMS; g++) begin : g_sram
      logic [sram_width(g)-1:0] dout0;
      logic [sram_width(g)-1:0] dout1;

      sram_1rw1r #(
         .DEPTH (sram_depth(g)),
         .WIDTH (sram_width(g))
      ) u_sram (
         .clk      (clk),
         .csb0_i   (csb0[g]),
         .web0_i   (web0),
         .wmask0_i (wmask0[sram_width(g)/8-1:0]),
         .addr0_i  (addr0),
         .din0_i   (din0[sram_width(g)-1:0]),
         .csb1_i   (csb1[g]),
         .addr1_i  (addr1),
         .dout0_o  (dout0),
         .dout1_o  (dout1)
      );

      // Byte-wide macro reads back zero-extended
      assign dout0_all[g] = DATA_SIZE'(dout0);
      assign dout1_all[g] = DATA_SIZE'(dout1);
   end

   result_unloader u_unloader (
      .clk         (clk),
      .resetn      (resetn),
      .cap_req_i   (cap_req),
      .cap_data_i  (cap_data),
      .unload_en_i (unload_en_i),
      .cap_ack_o   (cap_ack),
      .scan_out_o  (scan_out_o),
      .done_o      (done_o)
   );

endmodule

// ==== verification/sram_testchip_tb.sv ====
/*
 * Testbench for the SRAM test chip: table-driven commands checked
 * against a reference model of the four macros
 */
`timescale 1ns/1ps

module sram_testchip_tb;

   import sram_geom_pkg::*;
   import sram_cmd_pkg::*;

   logic clk;
   logic resetn;
   logic scan_in_i;
   logic scan_en_i;
   logic load_i;
   logic unload_en_i;
   logic scan_out_o;
   logic busy_o;
   logic done_o;

   // Stimulus table columns
   sram_op_e             q_op   [$];
   logic [1:0]           q_sel  [$];
   logic [ADDR_SIZE-1:0] q_a0   [$];
   logic [ADDR_SIZE-1:0] q_a1   [$];
   logic [3:0]           q_mask [$];
   logic                 q_rnd  [$];
   logic                 q_hold [$];
   logic [DATA_SIZE-1:0] q_din  [$];

   // Reference memories, one valid bit per byte
   int                   ref_depth [NUM_SRAMS] = '{SRAM_DEPTH0, SRAM_DEPTH1,
                                                   SRAM_DEPTH2, SRAM_DEPTH3};
   int                   ref_width [NUM_SRAMS] = '{SRAM_WIDTH0, SRAM_WIDTH1,
                                                   SRAM_WIDTH2, SRAM_WIDTH3};
   logic [DATA_SIZE-1:0] ref_mem   [NUM_SRAMS][1 << ADDR_SIZE];
   logic [3:0]           ref_valid [NUM_SRAMS][1 << ADDR_SIZE];

   int                   errors    = 0;
   int                   tests     = 0;
   int                   passed    = 0;
   int                   cycle_cnt = 0;
   int                   limit     = 0;
   logic [31:0]          lcg_state = 32'd96;
   int                   r;

   sram_testchip_top dut (
      .clk         (clk),
      .resetn      (resetn),
      .scan_in_i   (scan_in_i),
      .scan_en_i   (scan_en_i),
      .load_i      (load_i),
      .unload_en_i (unload_en_i),
      .scan_out_o  (scan_out_o),
      .busy_o      (busy_o),
      .done_o      (done_o)
   );

   initial clk = 1'b0;
   always #10 clk = ~clk;

   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (limit != 0 && cycle_cnt >= limit) begin
         $display("Timeout: the DUT did not finish within %0d cycles", limit);
         $display("FAIL: see errors above");
         $finish;
      end
   end

   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state;
   endfunction

   function automatic logic [DATA_SIZE-1:0] byte_care(input logic [3:0] v);
      logic [DATA_SIZE-1:0] m;
      int                   b;
      for (b = 0; b < 4; b++) begin
         m[b*8 +: 8] = {8{v[b]}};
      end
      return m;
   endfunction

   task automatic add_row(input sram_op_e op, input logic [1:0] sel,
                          input logic [ADDR_SIZE-1:0] a0, input logic [ADDR_SIZE-1:0] a1,
                          input logic [3:0] mask, input logic rnd, input logic hold,
                          input logic [DATA_SIZE-1:0] din);
      q_op.push_back(op);
      q_sel.push_back(sel);
      q_a0.push_back(a0);
      q_a1.push_back(a1);
      q_mask.push_back(mask);
      q_rnd.push_back(rnd);
      q_hold.push_back(hold);
      q_din.push_back(din);
   endtask

   task automatic build_table();
      // Write then read back on each macro
      add_row(OP_WRITE, 2'd0, 10'h012, 10'h012, 4'hF, 1'b0, 1'b0, 32'h0000_00A5);
      add_row(OP_READ,  2'd0, 10'h012, 10'h012, 4'h0, 1'b0, 1'b0, 32'h0);
      add_row(OP_WRITE, 2'd1, 10'h034, 10'h034, 4'hF, 1'b1, 1'b0, 32'h0);
      add_row(OP_READ,  2'd1, 10'h034, 10'h034, 4'h0, 1'b0, 1'b0, 32'h0);
      add_row(OP_WRITE, 2'd2, 10'h1F0, 10'h1F0, 4'hF, 1'b1, 1'b0, 32'h0);
      add_row(OP_READ,  2'd2, 10'h1F0, 10'h1F0, 4'h0, 1'b0, 1'b0, 32'h0);
      add_row(OP_WRITE, 2'd3, 10'h3C5, 10'h3C5, 4'hF, 1'b1, 1'b0, 32'h0);
      add_row(OP_READ,  2'd3, 10'h3C5, 10'h3C5, 4'h0, 1'b0, 1'b0, 32'h0);
      // Byte masks, port 1 on a second word
      add_row(OP_WRITE, 2'd1, 10'h035, 10'h034, 4'hF, 1'b1, 1'b0, 32'h0);
      add_row(OP_WRITE, 2'd1, 10'h034, 10'h035, 4'b0101, 1'b0, 1'b0, 32'hDEAD_BEEF);
      add_row(OP_READ,  2'd1, 10'h034, 10'h035, 4'h0, 1'b0, 1'b0, 32'h0);
      // Address wrap, first row also hits port 1 on the written word
      add_row(OP_WRITE, 2'd0, 10'h312, 10'h012, 4'hF, 1'b0, 1'b0, 32'h1234_565A);
      add_row(OP_READ,  2'd0, 10'h112, 10'h212, 4'h0, 1'b0, 1'b0, 32'h0);
      add_row(OP_WRITE, 2'd2, 10'h3F0, 10'h1F0, 4'hF, 1'b1, 1'b0, 32'h0);
      add_row(OP_NOP,   2'd2, 10'h1F0, 10'h1F0, 4'hF, 1'b0, 1'b0, 32'hFFFF_FFFF);
      add_row(OP_READ,  2'd2, 10'h1F0, 10'h3F0, 4'h0, 1'b0, 1'b0, 32'h0);
      add_row(OP_WRITE, 2'd3, 10'h1C5, 10'h3C5, 4'hF, 1'b1, 1'b0, 32'h0);
      add_row(OP_READ,  2'd3, 10'h3C5, 10'h1C5, 4'h0, 1'b0, 1'b0, 32'h0);
      // Second command held behind a full unloader
      add_row(OP_WRITE, 2'd1, 10'h0AA, 10'h035, 4'hF, 1'b1, 1'b1, 32'h0);
      add_row(OP_READ,  2'd1, 10'h0AA, 10'h034, 4'h0, 1'b0, 1'b0, 32'h0);
   endtask

   task automatic init_ref();
      int s;
      int a;
      int b;
      for (s = 0; s < NUM_SRAMS; s++) begin
         for (a = 0; a < (1 << ADDR_SIZE); a++) begin
            ref_mem[s][a]   = '0;
            // Bytes above a narrow macro read back as zero
            ref_valid[s][a] = 4'hF;
            for (b = 0; b < ref_width[s] / 8; b++) begin
               ref_valid[s][a][b] = 1'b0;
            end
         end
      end
   endtask

   task automatic predict(input int row, input logic [DATA_SIZE-1:0] din,
                          output logic [RESULT_WIDTH-1:0] exp,
                          output logic [RESULT_WIDTH-1:0] care);
      int s;
      int a0;
      int a1;
      int b;
      s  = q_sel[row];
      a0 = q_a0[row] % ref_depth[s];
      a1 = q_a1[row] % ref_depth[s];
      // Port 1 sees the word before this cycle's write
      exp[DATA_SIZE-1:0]  = ref_mem[s][a1];
      care[DATA_SIZE-1:0] = byte_care(ref_valid[s][a1]);
      if (q_op[row] == OP_WRITE) begin
         exp[RESULT_WIDTH-1:DATA_SIZE]  = '0;
         care[RESULT_WIDTH-1:DATA_SIZE] = '1;
         for (b = 0; b < ref_width[s] / 8; b++) begin
            if (q_mask[row][b]) begin
               ref_mem[s][a0][b*8 +: 8] = din[b*8 +: 8];
               ref_valid[s][a0][b]      = 1'b1;
            end
         end
      end else begin
         exp[RESULT_WIDTH-1:DATA_SIZE]  = ref_mem[s][a0];
         care[RESULT_WIDTH-1:DATA_SIZE] = byte_care(ref_valid[s][a0]);
      end
   endtask

   task automatic load_cmd(input logic [CMD_WIDTH-1:0] cmd);
      int i;
      for (i = CMD_WIDTH - 1; i >= 0; i--) begin
         @(posedge clk);
         scan_en_i <= 1'b1;
         scan_in_i <= cmd[i];
      end
      @(posedge clk);
      scan_en_i <= 1'b0;
      load_i    <= 1'b1;
      @(posedge clk);
      load_i <= 1'b0;
   endtask

   task automatic issue(input int row, output logic [RESULT_WIDTH-1:0] exp,
                        output logic [RESULT_WIDTH-1:0] care);
      logic [DATA_SIZE-1:0] din;
      din = q_rnd[row] ? lcg_next() : q_din[row];
      predict(row, din, exp, care);
      load_cmd({q_op[row], q_sel[row], q_a0[row], din, q_mask[row], q_a1[row]});
   endtask

   task automatic wait_done();
      @(negedge clk);
      while (!done_o) begin
         @(negedge clk);
      end
   endtask

   // First bit is visible before any shift
   task automatic unload_result(output logic [RESULT_WIDTH-1:0] got);
      int i;
      @(posedge clk);
      unload_en_i <= 1'b1;
      for (i = RESULT_WIDTH - 1; i >= 0; i--) begin
         @(negedge clk);
         got[i] = scan_out_o;
         @(posedge clk);
      end
      unload_en_i <= 1'b0;
   endtask

   task automatic check_result(input string name, input logic [RESULT_WIDTH-1:0] got,
                               input logic [RESULT_WIDTH-1:0] exp,
                               input logic [RESULT_WIDTH-1:0] care);
      if ((got & care) !== (exp & care)) begin
         $display("Fail at %0t: %s got %h expected %h (care %h)",
                  $time, name, got, exp, care);
         errors++;
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("Fail at %0t: %s got %b expected %b", $time, name, got, exp);
         errors++;
      end
   endtask

   task automatic report(input string label, input int err0);
      tests++;
      if (errors == err0) begin
         passed++;
         $display("Test %s: ok", label);
      end else begin
         $display("Test %s: failed", label);
      end
   endtask

   function automatic string row_label(input int row);
      return $sformatf("row %0d %s sel %0d", row, q_op[row].name(), q_sel[row]);
   endfunction

   task automatic run_access(input int row);
      logic [RESULT_WIDTH-1:0] exp;
      logic [RESULT_WIDTH-1:0] care;
      logic [RESULT_WIDTH-1:0] got;
      int                      err0;
      err0 = errors;
      issue(row, exp, care);
      wait_done();
      unload_result(got);
      check_result("scan_out_o result", got, exp, care);
      report(row_label(row), err0);
   endtask

   task automatic run_nop(input int row);
      logic [RESULT_WIDTH-1:0] exp;
      logic [RESULT_WIDTH-1:0] care;
      logic                    saw_done;
      int                      waited;
      int                      err0;
      err0     = errors;
      saw_done = 1'b0;
      waited   = 0;
      issue(row, exp, care);
      // A dropped command frees the loader within a few cycles
      @(negedge clk);
      while (busy_o && waited < 20) begin
         saw_done = saw_done | done_o;
         waited++;
         @(negedge clk);
      end
      saw_done = saw_done | done_o;
      check_flag("done_o during NOP", saw_done, 1'b0);
      check_flag("busy_o after NOP", busy_o, 1'b0);
      report(row_label(row), err0);
   endtask

   task automatic run_overlap(input int row);
      logic [RESULT_WIDTH-1:0] exp_a;
      logic [RESULT_WIDTH-1:0] care_a;
      logic [RESULT_WIDTH-1:0] exp_b;
      logic [RESULT_WIDTH-1:0] care_b;
      logic [RESULT_WIDTH-1:0] got;
      logic                    held;
      int                      err0;
      err0 = errors;
      issue(row, exp_a, care_a);
      wait_done();
      // Loader frees up once the first result is handed on
      while (busy_o) begin
         @(negedge clk);
      end
      issue(row + 1, exp_b, care_b);
      // A free handshake ends within about ten cycles, so busy_o
      // held well beyond that comes from the full unloader
      held = 1'b1;
      repeat (24) begin
         @(negedge clk);
         held = held & busy_o;
      end
      check_flag("busy_o with unloader full", held, 1'b1);
      check_flag("done_o with unloader full", done_o, 1'b1);
      unload_result(got);
      check_result("scan_out_o first result", got, exp_a, care_a);
      report(row_label(row), err0);
      err0 = errors;
      wait_done();
      unload_result(got);
      check_result("scan_out_o second result", got, exp_b, care_b);
      report(row_label(row + 1), err0);
   endtask

   initial begin
      resetn      = 1'b0;
      scan_in_i   = 1'b0;
      scan_en_i   = 1'b0;
      load_i      = 1'b0;
      unload_en_i = 1'b0;
      build_table();
      init_ref();
      limit = 2 * q_op.size() * 150;

      repeat (10) @(posedge clk);
      resetn <= 1'b1;
      @(negedge clk);
      check_flag("busy_o after reset", busy_o, 1'b0);
      check_flag("done_o after reset", done_o, 1'b0);
      check_flag("scan_out_o after reset", scan_out_o, 1'b0);
      report("reset", 0);

      r = 0;
      while (r < q_op.size()) begin
         if (q_op[r] == OP_NOP) begin
            run_nop(r);
            r = r + 1;
         end else if (q_hold[r] && r + 1 < q_op.size()) begin
            run_overlap(r);
            r = r + 2;
         end else begin
            run_access(r);
            r = r + 1;
         end
      end

      $display("Tests run %0d, passed %0d, failed %0d, check errors %0d",
               tests, passed, tests - passed, errors);
      if (errors == 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

endmodule

// ==== project.f ====
hdl/sram_geom_pkg.sv
hdl/sram_cmd_pkg.sv
hdl/scan_loader.sv
hdl/sram_sequencer.sv
hdl/sram_1rw1r.sv
hdl/result_unloader.sv
hdl/sram_testchip_top.sv
verification/sram_testchip_tb.sv

// ==== Makefile ====
# Verilator build and run of the SRAM test chip testbench

VERILATOR ?= verilator
TOP       ?= sram_testchip_tb
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

FAIL_MSG  := FAIL: see errors above
PASS_MSG  := PASS: all tests

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation did not complete"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
